/* hw/alu.sv */
`default_nettype none
`timescale 1ns/10ps
`include "rv_cfg.svh"

module alu (
    input  wire  [`XLEN-1:0]       a,
    input  wire  [`XLEN-1:0]       b,
    input  var   rv_pkg::alu_op_e  alu_ctrl,
    output logic [`XLEN-1:0]       result,
    output rv_pkg::alu_flags_t     flags
);
    import rv_pkg::*;

    localparam int SHW = $clog2(`XLEN);

    logic             sub_mode;
    logic [`XLEN-1:0] b_in;
    logic [`XLEN-1:0] sum;
    logic             carry;
    logic             ovf;
    logic [SHW-1:0]   shamt;

    // one adder for add, sub and both compares
    assign sub_mode = alu_ctrl inside {ALU_SUB, ALU_SLT, ALU_SLTU};
    assign b_in     = sub_mode ? ~b : b;
    assign {carry, sum} = {1'b0, a} + {1'b0, b_in} + {{`XLEN{1'b0}}, sub_mode};
    assign ovf      = (a[`XLEN-1] == b_in[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);
    assign shamt    = b[SHW-1:0];

    assign flags.neg   = sum[`XLEN-1];
    assign flags.zero  = (sum == '0);
    assign flags.carry = carry;  // set when a >= b on subtract
    assign flags.ovf   = ovf;

    always_comb begin
        case (alu_ctrl)
            ALU_ADD,
            ALU_SUB:  result = sum;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, sum[`XLEN-1] ^ ovf};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, !carry};
            default:  result = '0;
        endcase
    end
endmodule

`default_nettype wire

/* hw/controller.sv */
`default_nettype none
`timescale 1ns/10ps
`include "rv_cfg.svh"

module alu_dec (
    input  var   rv_pkg::op_e     op,
    input  wire  [2:0]            func3,
    input  wire  [6:0]            func7,
    output rv_pkg::alu_op_e       alu_ctrl
);
    import rv_pkg::*;

    alu_op_e arith_op;  // op picked by func3/func7 for R and I types

    always_comb begin
        case (func3)
            3'b000:  arith_op = (op == OP_R_TYPE && func7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = func7[5] ? ALU_SRA : ALU_SRL;  // srai keeps bit 30 too
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (op)
            OP_R_TYPE: alu_ctrl = arith_op;
            OP_I_TYPE: alu_ctrl = arith_op;
            OP_B_TYPE: alu_ctrl = ALU_SUB;  // flags drive the branch decision
            default:   alu_ctrl = ALU_ADD;  // addresses, auipc
        endcase
    end
endmodule

module controller (
    input  wire  [`XLEN-1:0]      instr,
    input  var   rv_pkg::alu_flags_t alu_flags,
    output rv_pkg::ctrl_t         ctrl
);
    import rv_pkg::*;

    op_e        op;
    logic [2:0] func3;
    logic [6:0] func7;
    alu_op_e    alu_ctrl;
    logic       br_taken;
    imm_src_e   imm_src_i_type;

    assign op    = op_e'(instr[6:0]);
    assign func3 = instr[14:12];
    assign func7 = instr[31:25];

    alu_dec alu_dec_i (
        .op       (op),
        .func3    (func3),
        .func7    (func7),
        .alu_ctrl (alu_ctrl)
    );

    // flags come from rs1 - rs2
    always_comb begin
        case (func3)
            3'b000:  br_taken = alu_flags.zero;                    // beq
            3'b001:  br_taken = !alu_flags.zero;                   // bne
            3'b100:  br_taken = alu_flags.neg ^ alu_flags.ovf;     // blt
            3'b101:  br_taken = !(alu_flags.neg ^ alu_flags.ovf);  // bge
            3'b110:  br_taken = !alu_flags.carry;                  // bltu, borrow
            3'b111:  br_taken = alu_flags.carry;                   // bgeu
            default: br_taken = 1'b0;
        endcase
    end

    // slli/srli/srai
    assign imm_src_i_type = (func3[1:0] == 2'b01) ? IMM_SRC_ITYPE2 : IMM_SRC_ITYPE;

    always_comb begin
        ctrl          = '0;  // unknown opcode, no side effects
        ctrl.alu_ctrl = alu_ctrl;
        case (op)
            OP_I_TYPE_L: begin
                ctrl.reg_we     = 1'b1;
                ctrl.mem_rd     = 1'b1;
                ctrl.alu_src    = ALU_SRC_EXT_IMM;
                ctrl.result_src = RES_SRC_READ_DATA;
            end
            OP_I_TYPE: begin
                ctrl.reg_we  = 1'b1;
                ctrl.alu_src = ALU_SRC_EXT_IMM;
                ctrl.imm_src = imm_src_i_type;
            end
            OP_S_TYPE: begin
                ctrl.mem_we  = 1'b1;
                ctrl.alu_src = ALU_SRC_EXT_IMM;
                ctrl.imm_src = IMM_SRC_STYPE;
            end
            OP_R_TYPE: ctrl.reg_we = 1'b1;
            OP_B_TYPE: begin
                ctrl.pc_src  = br_taken ? PC_SRC_PLUS_OFF : PC_SRC_PLUS_4;
                ctrl.imm_src = IMM_SRC_BTYPE;
            end
            OP_J_TYPE: begin
                ctrl.reg_we     = 1'b1;
                ctrl.result_src = RES_SRC_PC_PLUS_4;
                ctrl.pc_src     = PC_SRC_PLUS_OFF;
                ctrl.imm_src    = IMM_SRC_JTYPE;
            end
            OP_JALR: begin
                ctrl.reg_we     = 1'b1;
                ctrl.alu_src    = ALU_SRC_EXT_IMM;  // target comes out of the alu
                ctrl.result_src = RES_SRC_PC_PLUS_4;
                ctrl.pc_src     = PC_SRC_REG_PLUS_OFF;
            end
            OP_AUIPC: begin
                ctrl.reg_we  = 1'b1;
                ctrl.alu_src = ALU_SRC_PC_EXT_IMM;
                ctrl.imm_src = IMM_SRC_UTYPE;
            end
            default: ;
        endcase
    end
endmodule

`default_nettype wire

/* hw/imm_ext.sv */
`default_nettype none
`timescale 1ns/10ps
`include "rv_cfg.svh"

module imm_ext (
    input  wire  [`XLEN-1:0]       instr,
    input  var   rv_pkg::imm_src_e imm_src,
    output logic [`XLEN-1:0]       imm
);
    import rv_pkg::*;

    always_comb begin
        case (imm_src)
            IMM_SRC_ITYPE:  imm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            IMM_SRC_ITYPE2: imm = {{(`XLEN-5){1'b0}}, instr[24:20]};  // shamt
            IMM_SRC_STYPE:  imm = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            IMM_SRC_BTYPE:  imm = {{(`XLEN-13){instr[31]}}, instr[31], instr[7],
                                   instr[30:25], instr[11:8], 1'b0};
            IMM_SRC_JTYPE:  imm = {{(`XLEN-21){instr[31]}}, instr[31], instr[19:12],
                                   instr[20], instr[30:21], 1'b0};
            IMM_SRC_UTYPE:  imm = {instr[31:12], 12'b0};
            default:        imm = '0;
        endcase
    end
endmodule

`default_nettype wire

/* hw/regfile.sv */
`default_nettype none
`timescale 1ns/10ps
`include "rv_cfg.svh"

module regfile (
    input  wire                clk,
    input  wire  [4:0]         rs1,
    input  wire  [4:0]         rs2,
    output logic [`XLEN-1:0]   rd1,
    output logic [`XLEN-1:0]   rd2,
    input  wire                we,
    input  wire  [4:0]         wa,
    input  wire  [`XLEN-1:0]   wd
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // reads are combinational, x0 forced to zero
    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];
endmodule

`default_nettype wire

/* hw/rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and address width
`define XLEN      32

// architectural registers, x0 included
`define REG_COUNT 32

`define RESET_PC  32'h0000_0000  // first fetch address

`endif

/* hw/rv_core.sv */
`default_nettype none
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_core (
    input  wire                clk,
    input  wire                rst,
    output rv_pkg::wb_req_t    wb_req,
    input  var   rv_pkg::wb_rsp_t wb_rsp
);
    import rv_pkg::*;

    localparam logic [`XLEN-1:0] PC_STEP = 4;

    typedef enum logic [1:0] {S_FETCH, S_EXEC, S_MEM, S_WB} state_e;

    state_e           state;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] ir;
    logic             issued;   // bus access of this state already started

    ctrl_t            ctrl;
    alu_flags_t       alu_flags;
    logic [`XLEN-1:0] rd1, rd2, imm;
    logic [`XLEN-1:0] alu_a, alu_b, alu_result;
    logic [`XLEN-1:0] pc_plus_4, pc_target, next_pc, wb_data;

    logic             bus_start, bus_we, bus_done;
    logic [`XLEN-1:0] bus_adr, bus_rdata;

    controller controller_i (
        .instr     (ir),
        .alu_flags (alu_flags),
        .ctrl      (ctrl)
    );

    imm_ext imm_ext_i (
        .instr   (ir),
        .imm_src (ctrl.imm_src),
        .imm     (imm)
    );

    regfile regfile_i (
        .clk (clk),
        .rs1 (ir[19:15]),
        .rs2 (ir[24:20]),
        .rd1 (rd1),
        .rd2 (rd2),
        .we  (state == S_WB && ctrl.reg_we),
        .wa  (ir[11:7]),
        .wd  (wb_data)
    );

    // operand muxes
    assign alu_a = (ctrl.alu_src == ALU_SRC_PC_EXT_IMM) ? pc : rd1;
    assign alu_b = (ctrl.alu_src == ALU_SRC_REG) ? rd2 : imm;

    alu alu_i (
        .a        (alu_a),
        .b        (alu_b),
        .alu_ctrl (ctrl.alu_ctrl),
        .result   (alu_result),
        .flags    (alu_flags)
    );

    assign pc_plus_4 = pc + PC_STEP;
    assign pc_target = pc + imm;  // branches and jal

    always_comb begin
        case (ctrl.pc_src)
            PC_SRC_PLUS_OFF:     next_pc = pc_target;
            PC_SRC_REG_PLUS_OFF: next_pc = {alu_result[`XLEN-1:1], 1'b0};
            default:             next_pc = pc_plus_4;
        endcase
    end

    always_comb begin
        case (ctrl.result_src)
            RES_SRC_READ_DATA: wb_data = bus_rdata;  // load word from MEM
            RES_SRC_PC_PLUS_4: wb_data = pc_plus_4;
            default:           wb_data = alu_result;
        endcase
    end

    // fetch reads at pc, MEM uses the alu address
    assign bus_start = (state == S_FETCH || state == S_MEM) && !issued;
    assign bus_we    = (state == S_MEM) && ctrl.mem_we;
    assign bus_adr   = (state == S_MEM) ? alu_result : pc;

    wb_master wb_master_i (
        .clk    (clk),
        .rst    (rst),
        .start  (bus_start),
        .we     (bus_we),
        .adr    (bus_adr),
        .dat_w  (rd2),
        .done   (bus_done),
        .dat_r  (bus_rdata),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    // instruction state machine
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= S_FETCH;
            pc     <= `RESET_PC;
            issued <= 1'b0;
        end else begin
            if (bus_start) begin
                issued <= 1'b1;
            end else if (bus_done) begin
                issued <= 1'b0;
            end
            case (state)
                S_FETCH: if (bus_done) state <= S_EXEC;
                S_EXEC:  state <= (ctrl.mem_we || ctrl.mem_rd) ? S_MEM : S_WB;
                S_MEM:   if (bus_done) state <= S_WB;
                default: begin
                    pc    <= next_pc;  // instruction retires here
                    state <= S_FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_FETCH && bus_done) begin
            ir <= bus_rdata;
        end
    end
endmodule

`default_nettype wire

/* hw/rv_pkg.sv */
`default_nettype none
`include "rv_cfg.svh"

package rv_pkg;

    // opcode classes handled by the core
    typedef enum logic [6:0] {
        OP_I_TYPE_L = 7'b0000011,  // lw
        OP_I_TYPE   = 7'b0010011,
        OP_S_TYPE   = 7'b0100011,  // sw
        OP_R_TYPE   = 7'b0110011,
        OP_B_TYPE   = 7'b1100011,
        OP_J_TYPE   = 7'b1101111,  // jal
        OP_JALR     = 7'b1100111,
        OP_AUIPC    = 7'b0010111
    } op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU_SRC_REG,         // rs1, rs2
        ALU_SRC_EXT_IMM,     // rs1, imm
        ALU_SRC_PC_EXT_IMM   // pc, imm
    } alu_src_e;

    typedef enum logic [1:0] {
        RES_SRC_ALU_OUT,
        RES_SRC_READ_DATA,
        RES_SRC_PC_PLUS_4
    } res_src_e;

    typedef enum logic [1:0] {
        PC_SRC_PLUS_4,
        PC_SRC_PLUS_OFF,
        PC_SRC_REG_PLUS_OFF  // jalr
    } pc_src_e;

    typedef enum logic [2:0] {
        IMM_SRC_ITYPE,
        IMM_SRC_ITYPE2,  // shift amount only
        IMM_SRC_STYPE,
        IMM_SRC_BTYPE,
        IMM_SRC_JTYPE,
        IMM_SRC_UTYPE
    } imm_src_e;

    typedef struct packed {
        logic neg;
        logic zero;
        logic carry;
        logic ovf;
    } alu_flags_t;

    typedef struct packed {
        logic     reg_we;
        logic     mem_we;
        logic     mem_rd;
        alu_src_e alu_src;
        res_src_e result_src;
        pc_src_e  pc_src;
        imm_src_e imm_src;
        alu_op_e  alu_ctrl;
    } ctrl_t;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`XLEN/8-1:0]     sel;
        logic [`XLEN-1:0]       adr;
        logic [`XLEN-1:0]       dat_w;
    } wb_req_t;

    typedef struct packed {
        logic             ack;
        logic [`XLEN-1:0] dat_r;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* hw/wb_master.sv */
`default_nettype none
`timescale 1ns/10ps
`include "rv_cfg.svh"

module wb_master (
    input  wire                clk,
    input  wire                rst,
    input  wire                start,
    input  wire                we,
    input  wire  [`XLEN-1:0]   adr,
    input  wire  [`XLEN-1:0]   dat_w,
    output logic               done,
    output logic [`XLEN-1:0]   dat_r,
    output rv_pkg::wb_req_t    wb_req,
    input  var   rv_pkg::wb_rsp_t wb_rsp
);
    logic             cyc_q;
    logic             we_q;
    logic [`XLEN-1:0] adr_q;
    logic [`XLEN-1:0] dat_w_q;

    // cycle control
    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_q <= 1'b0;
            we_q  <= 1'b0;
            done  <= 1'b0;
        end else begin
            done <= cyc_q && wb_rsp.ack;  // one cycle after ack
            if (cyc_q && wb_rsp.ack) begin
                cyc_q <= 1'b0;
                we_q  <= 1'b0;
            end else if (!cyc_q && start) begin
                cyc_q <= 1'b1;
                we_q  <= we;
            end
        end
    end

    // request payload held through wait states
    always_ff @(posedge clk) begin
        if (!cyc_q && start) begin
            adr_q   <= adr;
            dat_w_q <= dat_w;
        end
        if (cyc_q && wb_rsp.ack) begin
            dat_r <= wb_rsp.dat_r;
        end
    end

    assign wb_req.cyc   = cyc_q;
    assign wb_req.stb   = cyc_q;  // classic, stb follows cyc
    assign wb_req.we    = we_q;
    assign wb_req.sel   = '1;
    assign wb_req.adr   = adr_q;
    assign wb_req.dat_w = dat_w_q;
endmodule

`default_nettype wire

/* rv_core.f */
+incdir+hw
hw/rv_pkg.sv
hw/controller.sv
hw/alu.sv
hw/regfile.sv
hw/imm_ext.sv
hw/wb_master.sv
hw/rv_core.sv
tb/tb_clock.sv
tb/rv_core_assertions.sv
tb/rv_core_tb.sv

/* tb/rv_core_assertions.sv */
`default_nettype none
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_core_assertions (
    input wire                  clk,
    input wire                  rst,
    input var rv_pkg::wb_req_t  wb_req,
    input var rv_pkg::wb_rsp_t  wb_rsp
);
    localparam int          NUM_RESULTS = 29;
    localparam logic [31:0] RESULT_BASE = 32'h100;

    // RV32I values of the result words, in store order
    localparam logic [31:0] EXPECTED [NUM_RESULTS] = '{
        32'hffff_fff9, 32'h0000_005d, 32'hffff_ff95, 32'h0000_0060,  // addi, add, sub, and
        32'hffff_fffd, 32'hffff_ff9d, 32'h0000_0320, 32'h1fff_ffff,  // or, xor, sll, srl
        32'hffff_ffff, 32'hffff_fffc, 32'h0000_0001, 32'h0000_0000,  // sra, srai, slt, sltu
        32'hffff_ff95, 32'h0000_0000,                                // load back, x0
        32'd1, 32'd2, 32'd1, 32'd2, 32'd1, 32'd2,                    // 1 taken, 2 not taken
        32'd1, 32'd2, 32'd1, 32'd2, 32'd1, 32'd2,
        32'h0000_12c0, 32'h0000_02cc, 32'h0000_02dc                  // auipc, jal, jalr
    };

    int          fail_count = 0;
    logic [31:0] res_idx;
    logic        in_results;
    logic [31:0] exp_word;
    logic        data_next;     // next access belongs to a lw or sw
    logic        jump_pending;  // last fetched instruction was a jal
    logic [31:0] jump_target;

    function automatic logic [31:0] jal_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    assign res_idx    = (wb_req.adr - RESULT_BASE) >> 2;
    assign in_results = wb_req.adr[1:0] == 2'b00 && res_idx < NUM_RESULTS;
    assign exp_word   = in_results ? EXPECTED[res_idx[4:0]] : '0;

    // follows fetch and data accesses from the fetched opcodes
    always_ff @(posedge clk) begin
        if (rst) begin
            data_next    <= 1'b0;
            jump_pending <= 1'b0;
            jump_target  <= '0;
        end else if (wb_req.stb && wb_rsp.ack) begin
            if (data_next) begin
                data_next <= 1'b0;
            end else begin
                data_next    <= wb_rsp.dat_r[6:0] inside {7'b0000011, 7'b0100011};
                jump_pending <= wb_rsp.dat_r[6:0] == 7'b1101111;
                jump_target  <= wb_req.adr + jal_offset(wb_rsp.dat_r);
            end
        end
    end

    idle_after_reset: assert property (@(posedge clk) rst |=> !wb_req.cyc && !wb_req.stb)
        else begin
            fail_count++;
            $error("bus cycle active right after reset");
        end

    first_fetch: assert property (@(posedge clk) $fell(rst) |=>
        wb_req.cyc && wb_req.adr == `RESET_PC)
        else begin
            fail_count++;
            $error("first fetch does not start at the reset address");
        end

    stb_in_cycle: assert property (@(posedge clk) disable iff (rst)
        wb_req.stb |-> wb_req.cyc && wb_req.sel == '1)
        else begin
            fail_count++;
            $error("stb high outside a bus cycle or with partial sel");
        end

    hold_request: assert property (@(posedge clk) disable iff (rst)
        wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr)
            && $stable(wb_req.we) && $stable(wb_req.dat_w))
        else begin
            fail_count++;
            $error("bus request changed during a wait state");
        end

    release_after_ack: assert property (@(posedge clk) disable iff (rst)
        wb_req.stb && wb_rsp.ack |=> !wb_req.stb && !wb_req.cyc)
        else begin
            fail_count++;
            $error("bus cycle not closed after ack");
        end

    store_value: assert property (@(posedge clk) disable iff (rst)
        wb_req.stb && wb_req.we && wb_rsp.ack && in_results |-> wb_req.dat_w == exp_word)
        else begin
            fail_count++;
            $error("error: wb_req.dat_w at %h is %h, expected %h",
                $sampled(wb_req.adr), $sampled(wb_req.dat_w), $sampled(exp_word));
        end

    jal_target: assert property (@(posedge clk) disable iff (rst)
        wb_req.stb && !data_next && jump_pending |-> wb_req.adr == jump_target)
        else begin
            fail_count++;
            $error("fetch after jal does not go to the jump target");
        end
endmodule

bind rv_core rv_core_assertions rv_core_assertions_i (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
);

`default_nettype wire

/* tb/rv_core_tb.sv */
`default_nettype none
`timescale 1ns/10ps

module rv_core_tb;
    import rv_pkg::*;

    localparam int          STIM_DELAY  = 1;   // ns after the rising edge
    localparam int          WORST_CPI   = 16;  // fetch and mem with 3 wait states each
    localparam logic [31:0] RESULT_BASE = 32'h100;
    localparam logic [31:0] CODE_CONT   = 32'h200;  // code resumes past the result area
    localparam logic [31:0] OPC_LOAD    = 32'h03;
    localparam logic [31:0] OPC_IMM     = 32'h13;
    localparam logic [31:0] OPC_AUIPC   = 32'h17;
    localparam logic [31:0] OPC_JALR    = 32'h67;

    logic        clk;
    logic        rst;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic [31:0] mem [1024];
    string       test_name [32];
    logic [9:0]  load_ptr;
    logic [9:0]  index;
    logic        last_we;
    logic [31:0] last_adr;
    int          seed;
    int          wait_left;
    int          num_results;
    int          num_instr;
    int          tests_done = 0;
    int          tests_bad = 0;
    int          seen_fails = 0;
    logic        program_ready = 1'b0;

    tb_clock #(.PERIOD_NS(100), .RESET_CYCLES(2)) tb_clock_i (.clk(clk), .rst(rst));

    rv_core dut_i (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    function automatic logic [31:0] r_format(input logic [31:0] f7, rs2, rs1, f3, rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_format(input logic [31:0] imm, rs1, f3, rd, op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] s_format(input logic [31:0] rs2, rs1, imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_format(input logic [31:0] f3, rs1, rs2, off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] j_format(input logic [31:0] rd, off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    function automatic logic [31:0] u_format(input logic [31:0] imm20, rd, op);
        return {imm20[19:0], rd[4:0], op[6:0]};
    endfunction

    task automatic emit(input logic [31:0] word);
        mem[load_ptr] = word;
        load_ptr++;
        num_instr++;
    endtask

    task automatic alu_rr(input logic [31:0] f7, f3, rd, rs1, rs2);
        emit(r_format(f7, rs2, rs1, f3, rd));
    endtask

    task automatic op_imm(input logic [31:0] f3, rd, rs1, imm);
        emit(i_format(imm, rs1, f3, rd, OPC_IMM));
    endtask

    task automatic store_result(input logic [31:0] rs, input string name);
        test_name[num_results] = name;
        emit(s_format(rs, 0, RESULT_BASE + 4 * num_results));
        num_results++;
    endtask

    // x20 ends as 1 on the taken path, 2 on the fall-through path
    task automatic branch_case(input logic [31:0] f3, rs1, rs2, input string name);
        op_imm(0, 20, 0, 1);
        emit(b_format(f3, rs1, rs2, 8));
        op_imm(0, 20, 0, 2);
        store_result(20, name);
    endtask

    task automatic report_test(input logic [31:0] adr);
        int fails_now;
        fails_now = dut_i.rv_core_assertions_i.fail_count;
        tests_done++;
        if (fails_now != seen_fails) begin
            tests_bad++;
            $display("test %0d %s at %h: mismatch", tests_done,
                test_name[(adr - RESULT_BASE) >> 2], adr);
        end else begin
            $display("test %0d %s at %h: ok", tests_done,
                test_name[(adr - RESULT_BASE) >> 2], adr);
        end
        seen_fails = fails_now;
    endtask

    initial begin
        wb_rsp      = '0;
        seed        = 19198;
        wait_left   = {$random(seed)} % 4;
        load_ptr    = '0;
        num_results = 0;
        num_instr   = 0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'ha5a5_0000 | (i << 2);  // fill tagged with its address
        end
        op_imm(0, 1, 0, -7);                   // x1 = -7
        store_result(1, "addi negative");
        op_imm(0, 2, 0, 100);                  // x2 = 100
        alu_rr(0, 0, 3, 1, 2);
        store_result(3, "add");
        alu_rr(32, 0, 4, 1, 2);
        store_result(4, "sub");
        alu_rr(0, 7, 5, 1, 2);
        store_result(5, "and");
        alu_rr(0, 6, 6, 1, 2);
        store_result(6, "or");
        alu_rr(0, 4, 7, 1, 2);
        store_result(7, "xor");
        op_imm(0, 8, 0, 3);                    // shift amount
        alu_rr(0, 1, 9, 2, 8);
        store_result(9, "sll");
        alu_rr(0, 5, 10, 1, 8);
        store_result(10, "srl");
        alu_rr(32, 5, 11, 1, 8);
        store_result(11, "sra");
        op_imm(5, 12, 1, 32'h401);             // srai x12, x1, 1
        store_result(12, "srai");
        alu_rr(0, 2, 13, 1, 2);
        store_result(13, "slt");
        alu_rr(0, 3, 14, 1, 2);
        store_result(14, "sltu");
        emit(s_format(4, 0, 32'h300));         // scratch word
        emit(i_format(32'h300, 0, 2, 15, OPC_LOAD));
        store_result(15, "lw after sw");
        op_imm(0, 0, 0, 5);
        store_result(0, "x0 write");
        emit(j_format(0, CODE_CONT - 4 * load_ptr));  // hop over the result area
        load_ptr = CODE_CONT >> 2;
        branch_case(0, 1, 1, "beq taken");
        branch_case(0, 1, 2, "beq not taken");
        branch_case(1, 1, 2, "bne taken");
        branch_case(1, 1, 1, "bne not taken");
        branch_case(4, 1, 2, "blt taken");
        branch_case(4, 2, 1, "blt not taken");
        branch_case(5, 2, 1, "bge taken");
        branch_case(5, 1, 2, "bge not taken");
        branch_case(6, 2, 1, "bltu taken");
        branch_case(6, 1, 2, "bltu not taken");
        branch_case(7, 1, 2, "bgeu taken");
        branch_case(7, 2, 1, "bgeu not taken");
        emit(u_format(1, 21, OPC_AUIPC));      // at 0x2c0
        store_result(21, "auipc");
        emit(j_format(22, 8));                 // at 0x2c8
        op_imm(0, 22, 0, 32'h7ff);             // skipped
        store_result(22, "jal link");
        emit(u_format(0, 23, OPC_AUIPC));      // x23 = 0x2d4
        emit(i_format(12, 23, 0, 24, OPC_JALR));
        op_imm(0, 24, 0, 32'h7ff);             // skipped
        store_result(24, "jalr link");
        emit(j_format(0, 0));                  // park here
        program_ready = 1'b1;
    end

    // memory model, 0 to 3 wait states per access
    always @(posedge clk) begin
        #STIM_DELAY;
        if (wb_rsp.ack) begin
            wb_rsp.ack = 1'b0;
            if (last_we && last_adr - RESULT_BASE < 32'(4 * num_results)) begin
                report_test(last_adr);
            end
        end else if (wb_req.cyc && wb_req.stb) begin
            if (wait_left > 0) begin
                wait_left--;
            end else begin
                index = wb_req.adr[11:2];
                if (wb_req.we) begin
                    mem[index] = wb_req.dat_w;
                end
                wb_rsp.dat_r = mem[index];
                wb_rsp.ack   = 1'b1;
                last_we      = wb_req.we;
                last_adr     = wb_req.adr;
                wait_left    = {$random(seed)} % 4;
            end
        end
    end

    initial begin
        wait (program_ready);
        wait (tests_done == num_results);
        @(posedge clk);
        $display("%0d of %0d tests run, %0d with mismatches, %0d assertion failures",
            tests_done, num_results, tests_bad, dut_i.rv_core_assertions_i.fail_count);
        if (tests_bad == 0 && dut_i.rv_core_assertions_i.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // instructions times worst case cycles, doubled
    initial begin
        wait (program_ready);
        repeat (num_instr * WORST_CPI * 2) @(posedge clk);
        $display("watchdog expired, the core stalled after %0d of %0d result stores",
            tests_done, num_results);
        $display("tests failed");
        $finish;
    end
endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`default_nettype none
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // released just after an edge, like the rest of the stimulus
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end
endmodule

`default_nettype wire
